/* source/lc3b_macros.svh */
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// byte address width of the memory port
`define LC3B_ADDR_W 16

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

// repeated fetches at one address that count as a halt
`define LC3B_HALT_DEPTH 4

`endif

/* source/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;   // n, z, p condition codes

    // 1011 and 1101 are unused
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_shf  = 4'b1010,
        op_jmp  = 4'b1100,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        lc3b_alu_op_pass,
        lc3b_alu_op_add,
        lc3b_alu_op_and,
        lc3b_alu_op_not,
        lc3b_alu_op_sll,
        lc3b_alu_op_srl,
        lc3b_alu_op_sra
    } lc3b_alu_op;

endpackage

/* source/lc3b_ctrl_pkg.sv */
package lc3b_ctrl_pkg;

    typedef enum logic [1:0] {
        lc3b_pc_mux_sel_pc_plus2,
        lc3b_pc_mux_sel_pcn,
        lc3b_pc_mux_sel_alu
    } lc3b_pc_mux_sel;

    typedef enum logic [1:0] {
        lc3b_general_alu_mux_sel_sr2,
        lc3b_general_alu_mux_sel_imm5,
        lc3b_general_alu_mux_sel_imm4,
        lc3b_general_alu_mux_sel_offset6_w
    } lc3b_general_alu_mux_sel;

    typedef enum logic [1:0] {
        lc3b_cc_gen_mux_sel_alu,
        lc3b_cc_gen_mux_sel_pcn,
        lc3b_cc_gen_mux_sel_mdr
    } lc3b_cc_gen_mux_sel;

    typedef enum logic [1:0] {
        lc3b_regfile_data_mux_sel_alu,
        lc3b_regfile_data_mux_sel_pcn,
        lc3b_regfile_data_mux_sel_mdr
    } lc3b_regfile_data_mux_sel;

    typedef struct packed {
        logic                        conditional_branch;
        lc3b_pc_mux_sel              pc_mux_sel;
        lc3b_general_alu_mux_sel     general_alu_mux_sel;
        lc3b_isa_pkg::lc3b_alu_op    general_alu_op;
        logic                        cc_load;
        lc3b_cc_gen_mux_sel          cc_gen_mux_sel;
        logic                        data_memory_read;
        logic                        data_memory_write_enable;
        lc3b_regfile_data_mux_sel    regfile_data_mux_sel;
        logic                        regfile_load;
    } lc3b_control_word;

    typedef enum logic [1:0] {
        exec_idle,
        exec_execute,
        exec_mem_wait
    } exec_state_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_setup,
        arb_access
    } arb_state_t;

endpackage

/* source/control_rom.sv */
`timescale 1ns/1ps

module control_rom (
    input  lc3b_isa_pkg::lc3b_word          ir_in,
    output lc3b_ctrl_pkg::lc3b_control_word control_out
);

    lc3b_isa_pkg::lc3b_opcode opcode;

    assign opcode = lc3b_isa_pkg::lc3b_opcode'(ir_in[15:12]);

    always_comb begin
        control_out = '0;  // pc+2, nothing loaded

        case (opcode)
            lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and: begin
                if (ir_in[5] == 1'b0)
                    control_out.general_alu_mux_sel = lc3b_ctrl_pkg::lc3b_general_alu_mux_sel_sr2;
                else
                    control_out.general_alu_mux_sel = lc3b_ctrl_pkg::lc3b_general_alu_mux_sel_imm5;
                if (opcode == lc3b_isa_pkg::op_add)
                    control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_add;
                else
                    control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_and;
                control_out.cc_load = 1'b1;
                control_out.regfile_load = 1'b1;
            end

            lc3b_isa_pkg::op_not: begin
                control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_not;
                control_out.cc_load = 1'b1;
                control_out.regfile_load = 1'b1;
            end

            lc3b_isa_pkg::op_shf: begin
                control_out.general_alu_mux_sel = lc3b_ctrl_pkg::lc3b_general_alu_mux_sel_imm4;
                if (ir_in[4] == 1'b0)
                    control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_sll;
                else if (ir_in[5] == 1'b0)
                    control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_srl;
                else
                    control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_sra;
                control_out.cc_load = 1'b1;
                control_out.regfile_load = 1'b1;
            end

            lc3b_isa_pkg::op_lea: begin
                control_out.cc_load = 1'b1;
                control_out.cc_gen_mux_sel = lc3b_ctrl_pkg::lc3b_cc_gen_mux_sel_pcn;
                control_out.regfile_data_mux_sel = lc3b_ctrl_pkg::lc3b_regfile_data_mux_sel_pcn;
                control_out.regfile_load = 1'b1;
            end

            lc3b_isa_pkg::op_ldr: begin
                control_out.general_alu_mux_sel =
                    lc3b_ctrl_pkg::lc3b_general_alu_mux_sel_offset6_w;
                control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_add;
                control_out.data_memory_read = 1'b1;
                control_out.cc_load = 1'b1;
                control_out.cc_gen_mux_sel = lc3b_ctrl_pkg::lc3b_cc_gen_mux_sel_mdr;
                control_out.regfile_data_mux_sel = lc3b_ctrl_pkg::lc3b_regfile_data_mux_sel_mdr;
                control_out.regfile_load = 1'b1;
            end

            lc3b_isa_pkg::op_str: begin
                control_out.general_alu_mux_sel =
                    lc3b_ctrl_pkg::lc3b_general_alu_mux_sel_offset6_w;
                control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_add;
                control_out.data_memory_write_enable = 1'b1;  // write
            end

            lc3b_isa_pkg::op_br: begin
                control_out.conditional_branch = 1'b1;  // taken only if nzp matches
                control_out.pc_mux_sel = lc3b_ctrl_pkg::lc3b_pc_mux_sel_pcn;
            end

            lc3b_isa_pkg::op_jmp: begin
                control_out.pc_mux_sel = lc3b_ctrl_pkg::lc3b_pc_mux_sel_alu;
                control_out.general_alu_op = lc3b_isa_pkg::lc3b_alu_op_pass;  // baser
            end

            default: begin
                control_out = '0;  // ldb, stb, jsr, trap, rti and unused codes
            end
        endcase
    end

endmodule : control_rom

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module fetch_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic                    fetch_req,
    output logic [`LC3B_ADDR_W-1:0] fetch_addr,
    input  logic                    fetch_done,
    input  lc3b_isa_pkg::lc3b_word  rdata,
    output logic                    instr_valid,
    output lc3b_isa_pkg::lc3b_word  instr,
    output logic [`LC3B_ADDR_W-1:0] instr_pc,
    input  logic                    instr_taken,
    input  logic                    redirect,
    input  logic [`LC3B_ADDR_W-1:0] redirect_pc
);

    logic [`LC3B_ADDR_W-1:0] pc;       // next address to request
    logic                    discard;  // in-flight fetch went stale

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_req   <= 1'b1;  // first fetch leaves right after reset
            fetch_addr  <= `LC3B_RESET_PC;
            pc          <= `LC3B_RESET_PC + `LC3B_ADDR_W'(2);
            discard     <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (instr_taken || redirect)
                instr_valid <= 1'b0;
            if (redirect)
                pc <= redirect_pc;

            if (fetch_done) begin
                fetch_req <= 1'b0;
                discard   <= 1'b0;
                if (!discard && !redirect)
                    instr_valid <= 1'b1;
            end else if (fetch_req && redirect) begin
                discard <= 1'b1;  // drop the data when it arrives
            end else if (!fetch_req && (!instr_valid || instr_taken) && !redirect) begin
                fetch_req  <= 1'b1;
                fetch_addr <= pc;
                pc         <= pc + `LC3B_ADDR_W'(2);
            end
        end
    end

    // one-entry buffer, tagged with its pc
    always_ff @(posedge clk) begin
        if (fetch_done && !discard) begin
            instr    <= rdata;
            instr_pc <= fetch_addr;
        end
    end

    a_fetch_addr_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        fetch_req && !fetch_done |=> $stable(fetch_addr)
    ) else $error("fetch_addr moved during a pending fetch");

endmodule : fetch_unit

/* source/exec_unit.sv */
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module exec_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    input  lc3b_isa_pkg::lc3b_word  instr,
    input  logic [`LC3B_ADDR_W-1:0] instr_pc,
    output logic                    instr_taken,
    output logic                    redirect,
    output logic [`LC3B_ADDR_W-1:0] redirect_pc,
    output logic                    data_req,
    output logic                    data_write,
    output logic [`LC3B_ADDR_W-1:0] data_addr,
    output lc3b_isa_pkg::lc3b_word  data_wdata,
    input  logic                    data_done,
    input  lc3b_isa_pkg::lc3b_word  rdata
);

    lc3b_ctrl_pkg::exec_state_t      state;
    lc3b_ctrl_pkg::lc3b_control_word cw;
    lc3b_isa_pkg::lc3b_word          ir;
    logic [`LC3B_ADDR_W-1:0]         ir_pc;
    lc3b_isa_pkg::lc3b_word          regs [8];
    lc3b_isa_pkg::lc3b_nzp           cc;
    lc3b_isa_pkg::lc3b_reg           dest;
    lc3b_isa_pkg::lc3b_word          sr1;
    lc3b_isa_pkg::lc3b_word          alu_b;
    lc3b_isa_pkg::lc3b_word          alu_out;
    lc3b_isa_pkg::lc3b_word          pc_plus2;
    lc3b_isa_pkg::lc3b_word          pcn;
    lc3b_isa_pkg::lc3b_word          wb_data;
    lc3b_isa_pkg::lc3b_word          cc_data;
    logic                            mem_op;
    logic                            br_en;
    logic                            wb_en;

    control_rom rom (
        .ir_in       (ir),
        .control_out (cw)
    );

    assign dest     = ir[11:9];
    assign sr1      = regs[ir[8:6]];
    assign pc_plus2 = ir_pc + `LC3B_ADDR_W'(2);
    assign pcn      = pc_plus2 + {{6{ir[8]}}, ir[8:0], 1'b0};  // offset9 in words

    always_comb begin
        case (cw.general_alu_mux_sel)
            lc3b_ctrl_pkg::lc3b_general_alu_mux_sel_imm5: alu_b = {{11{ir[4]}}, ir[4:0]};
            lc3b_ctrl_pkg::lc3b_general_alu_mux_sel_imm4: alu_b = {12'b0, ir[3:0]};
            lc3b_ctrl_pkg::lc3b_general_alu_mux_sel_offset6_w: alu_b = {{9{ir[5]}}, ir[5:0], 1'b0};
            default: alu_b = regs[ir[2:0]];
        endcase
    end

    always_comb begin
        case (cw.general_alu_op)
            lc3b_isa_pkg::lc3b_alu_op_add: alu_out = sr1 + alu_b;
            lc3b_isa_pkg::lc3b_alu_op_and: alu_out = sr1 & alu_b;
            lc3b_isa_pkg::lc3b_alu_op_not: alu_out = ~sr1;
            lc3b_isa_pkg::lc3b_alu_op_sll: alu_out = sr1 << alu_b[3:0];
            lc3b_isa_pkg::lc3b_alu_op_srl: alu_out = sr1 >> alu_b[3:0];
            lc3b_isa_pkg::lc3b_alu_op_sra: alu_out = $signed(sr1) >>> alu_b[3:0];
            default: alu_out = sr1;  // pass
        endcase
    end

    always_comb begin
        case (cw.regfile_data_mux_sel)
            lc3b_ctrl_pkg::lc3b_regfile_data_mux_sel_pcn: wb_data = pcn;
            lc3b_ctrl_pkg::lc3b_regfile_data_mux_sel_mdr: wb_data = rdata;
            default: wb_data = alu_out;
        endcase
        case (cw.cc_gen_mux_sel)
            lc3b_ctrl_pkg::lc3b_cc_gen_mux_sel_pcn: cc_data = pcn;
            lc3b_ctrl_pkg::lc3b_cc_gen_mux_sel_mdr: cc_data = rdata;
            default: cc_data = alu_out;
        endcase
    end

    assign mem_op = cw.data_memory_read || cw.data_memory_write_enable;
    assign br_en  = !cw.conditional_branch || (|(ir[11:9] & cc));

    // alu ops write in execute, loads when the data returns
    assign wb_en = (state == lc3b_ctrl_pkg::exec_execute && !mem_op)
                || (state == lc3b_ctrl_pkg::exec_mem_wait && data_done);

    assign instr_taken = (state == lc3b_ctrl_pkg::exec_idle) && instr_valid;
    assign redirect    = (state == lc3b_ctrl_pkg::exec_execute) && br_en
                      && (cw.pc_mux_sel != lc3b_ctrl_pkg::lc3b_pc_mux_sel_pc_plus2);
    assign redirect_pc = (cw.pc_mux_sel == lc3b_ctrl_pkg::lc3b_pc_mux_sel_alu) ? alu_out : pcn;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= lc3b_ctrl_pkg::exec_idle;
            data_req   <= 1'b0;
            data_write <= 1'b0;
            cc         <= 3'b010;  // come up as zero
        end else begin
            case (state)
                lc3b_ctrl_pkg::exec_idle: begin
                    if (instr_valid)
                        state <= lc3b_ctrl_pkg::exec_execute;
                end
                lc3b_ctrl_pkg::exec_execute: begin
                    if (mem_op) begin
                        state      <= lc3b_ctrl_pkg::exec_mem_wait;
                        data_req   <= 1'b1;
                        data_write <= cw.data_memory_write_enable;
                    end else begin
                        state <= lc3b_ctrl_pkg::exec_idle;
                    end
                end
                default: begin
                    if (data_done) begin
                        state    <= lc3b_ctrl_pkg::exec_idle;
                        data_req <= 1'b0;
                    end
                end
            endcase
            if (wb_en && cw.cc_load)
                cc <= {cc_data[15], cc_data == 16'h0, !cc_data[15] && cc_data != 16'h0};
        end
    end

    always_ff @(posedge clk) begin
        if (instr_taken) begin
            ir    <= instr;
            ir_pc <= instr_pc;
        end
        if (state == lc3b_ctrl_pkg::exec_execute && mem_op) begin
            data_addr  <= {alu_out[15:1], 1'b0};  // word aligned
            data_wdata <= regs[dest];
        end
        if (wb_en && cw.regfile_load)
            regs[dest] <= wb_data;
    end

    a_no_req_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        state == lc3b_ctrl_pkg::exec_idle |-> !data_req
    ) else $error("data request left pending in idle");

endmodule : exec_unit

/* source/mem_arbiter.sv */
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module mem_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    fetch_req,
    input  logic [`LC3B_ADDR_W-1:0] fetch_addr,
    output logic                    fetch_done,
    input  logic                    data_req,
    input  logic                    data_write,
    input  logic [`LC3B_ADDR_W-1:0] data_addr,
    input  lc3b_isa_pkg::lc3b_word  data_wdata,
    output logic                    data_done,
    output lc3b_isa_pkg::lc3b_word  rdata,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [`LC3B_ADDR_W-1:0] paddr,
    output lc3b_isa_pkg::lc3b_word  pwdata,
    input  lc3b_isa_pkg::lc3b_word  prdata,
    input  logic                    pready
);

    lc3b_ctrl_pkg::arb_state_t state;
    logic                      grant_data;  // current transfer is the execute unit's
    logic                      xfer_end;

    assign psel       = (state != lc3b_ctrl_pkg::arb_idle);
    assign penable    = (state == lc3b_ctrl_pkg::arb_access);
    assign xfer_end   = penable && pready;
    assign fetch_done = xfer_end && !grant_data;
    assign data_done  = xfer_end && grant_data;
    assign rdata      = prdata;  // valid with the done pulse

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= lc3b_ctrl_pkg::arb_idle;
            grant_data <= 1'b0;
            pwrite     <= 1'b0;
        end else begin
            case (state)
                lc3b_ctrl_pkg::arb_idle: begin
                    if (data_req) begin  // data beats fetch
                        state      <= lc3b_ctrl_pkg::arb_setup;
                        grant_data <= 1'b1;
                        pwrite     <= data_write;
                    end else if (fetch_req) begin
                        state      <= lc3b_ctrl_pkg::arb_setup;
                        grant_data <= 1'b0;
                        pwrite     <= 1'b0;
                    end
                end
                lc3b_ctrl_pkg::arb_setup: state <= lc3b_ctrl_pkg::arb_access;
                default: begin
                    if (pready) begin
                        state  <= lc3b_ctrl_pkg::arb_idle;
                        pwrite <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == lc3b_ctrl_pkg::arb_idle) begin
            paddr <= data_req ? data_addr : fetch_addr;
            if (data_req)
                pwdata <= data_wdata;
        end
    end

    a_penable_in_psel: assert property (
        @(posedge clk) disable iff (!arst_n)
        penable |-> psel && $past(psel)
    ) else $error("penable without a setup phase");

endmodule : mem_arbiter

/* source/lc3b_core.sv */
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module lc3b_core (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output logic [`LC3B_ADDR_W-1:0] paddr,
    output lc3b_isa_pkg::lc3b_word  pwdata,
    input  lc3b_isa_pkg::lc3b_word  prdata,
    input  logic                    pready
);

    logic                    fetch_req;
    logic [`LC3B_ADDR_W-1:0] fetch_addr;
    logic                    fetch_done;
    logic                    data_req;
    logic                    data_write;
    logic [`LC3B_ADDR_W-1:0] data_addr;
    lc3b_isa_pkg::lc3b_word  data_wdata;
    logic                    data_done;
    lc3b_isa_pkg::lc3b_word  rdata;     // shared read return
    logic                    instr_valid;
    lc3b_isa_pkg::lc3b_word  instr;
    logic [`LC3B_ADDR_W-1:0] instr_pc;
    logic                    instr_taken;
    logic                    redirect;
    logic [`LC3B_ADDR_W-1:0] redirect_pc;

    fetch_unit fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_done  (fetch_done),
        .rdata       (rdata),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_taken (instr_taken),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    exec_unit exec (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_taken (instr_taken),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .data_req    (data_req),
        .data_write  (data_write),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_done   (data_done),
        .rdata       (rdata)
    );

    mem_arbiter arbiter (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_done (fetch_done),
        .data_req   (data_req),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_done  (data_done),
        .rdata      (rdata),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready)
    );

endmodule : lc3b_core

/* tb/tb_lc3b_core.sv */
`timescale 1ns/1ps
`include "lc3b_macros.svh"

module tb_lc3b_core;

    localparam logic [15:0] DATA_BASE = 16'h4000;  // r6 holds this
    localparam int          DUMP_OFF  = 24;        // dump words follow the data words
    localparam int          N_BLOCKS  = 60;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;

    logic [15:0] mem [32768];        // 64 KiB behind the APB slave
    logic [15:0] model_mem [32768];  // ISA model's own copy
    logic [15:0] model_regs [8];
    logic [2:0]  model_cc;
    logic [15:0] exp_addr_q [$];
    logic [15:0] exp_data_q [$];
    logic [15:0] exp_addr;
    logic [15:0] exp_data;
    logic [15:0] halt_pc;
    logic        halted;
    logic        next_pready;
    logic [15:0] next_prdata;
    int          prog_wp;
    int          model_count;
    int          cycle_limit;
    int          cycle_count;
    int          halt_hits;
    int          wait_left;

    lc3b_core uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic value_mismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        abort_run();
    endtask

    task automatic plain_error(input string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    task automatic emit(input logic [15:0] word);
        mem[15'(prog_wp)] = word;
        prog_wp = prog_wp + 1;
    endtask

    // any register except the data pointer r6
    function automatic logic [2:0] pick_dest();
        logic [2:0] r;
        r = 3'($urandom % 7);
        return (r == 3'd6) ? 3'd7 : r;
    endfunction

    function automatic logic [15:0] alu_word();
        logic [2:0] dr;
        logic [2:0] sa;
        logic [2:0] sb;
        dr = pick_dest();
        sa = 3'($urandom);
        sb = 3'($urandom);
        case ($urandom % 6)
            0: return {4'b0001, dr, sa, 3'b000, sb};
            1: return {4'b0001, dr, sa, 1'b1, 5'($urandom)};
            2: return {4'b0101, dr, sa, 3'b000, sb};
            3: return {4'b0101, dr, sa, 1'b1, 5'($urandom)};
            4: return {4'b1001, dr, sa, 6'h3f};
            default: return {4'b1010, dr, sa, 2'($urandom), 4'($urandom)};  // shf
        endcase
    endfunction

    // ldb, stb, jsr, rti, two unused codes, trap
    function automatic logic [15:0] reserved_word();
        logic [3:0] op;
        case ($urandom % 7)
            0: op = 4'b0010;
            1: op = 4'b0011;
            2: op = 4'b0100;
            3: op = 4'b1000;
            4: op = 4'b1011;
            5: op = 4'b1101;
            default: op = 4'b1111;
        endcase
        return {op, 12'($urandom)};
    endfunction

    task automatic build_program();
        int i;
        int blk;
        int kind;
        int s;
        for (i = 0; i < 32768; i++)
            mem[15'(i)] = 16'(i * 2) * 16'h9e37 + 16'h3c5a;  // pattern of the byte address
        prog_wp = `LC3B_RESET_PC >> 1;
        for (i = 0; i < 8; i++) begin
            if (i != 6) begin
                emit({4'b0101, 3'(i), 3'(i), 1'b1, 5'b0});
                emit({4'b0001, 3'(i), 3'(i), 1'b1, 5'($urandom)});
            end
        end
        emit(16'h5da0);  // and r6, r6, #0
        emit(16'h1da1);  // add r6, r6, #1
        emit(16'had8e);  // lshf r6, r6, #14
        for (blk = 0; blk < N_BLOCKS; blk++) begin
            kind = (blk == N_BLOCKS / 2) ? 8 : int'($urandom % 10);
            case (kind)
                0, 1, 2, 3: emit(alu_word());
                4: emit({4'b1110, pick_dest(), 9'($urandom)});
                5: emit({4'b0110, pick_dest(), 3'd6, 6'($urandom % 32)});
                6: emit({4'b0111, 3'($urandom), 3'd6, 6'($urandom % DUMP_OFF)});
                7: begin
                    s = 1 + int'($urandom % 3);  // forward over s fillers
                    emit({4'b0000, 3'($urandom), 9'(s)});
                    repeat (s) emit(alu_word());
                end
                8: begin
                    s = int'($urandom % 3);
                    emit({4'b1110, 3'd7, 9'(s + 1)});
                    emit(16'hc1c0);  // jmp r7
                    repeat (s) emit(alu_word());
                end
                default: emit(reserved_word());
            endcase
        end
        for (i = 0; i < 8; i++)
            emit({4'b0111, 3'(i), 3'd6, 6'(DUMP_OFF + i)});
        halt_pc = 16'(prog_wp * 2);
        emit(16'h0fff);  // br nzp to itself
        for (i = 0; i < 32768; i++)
            model_mem[15'(i)] = mem[15'(i)];
    endtask

    task automatic commit_result(input logic [2:0] dest, input logic [15:0] value);
        model_regs[dest] = value;
        if (value == 16'h0)
            model_cc = 3'b010;
        else if (value[15])
            model_cc = 3'b100;
        else
            model_cc = 3'b001;
    endtask

    task automatic run_model();
        logic [15:0] pc;
        logic [15:0] ir;
        logic [15:0] next_pc;
        logic [15:0] opb;
        logic [15:0] base;
        logic [15:0] addr;
        logic [15:0] res;
        int          i;
        pc = `LC3B_RESET_PC;
        model_cc = 3'b010;
        model_count = 0;
        for (i = 0; i < 8; i++)
            model_regs[3'(i)] = 16'h0;
        while (pc != halt_pc) begin
            ir      = model_mem[pc[15:1]];
            next_pc = pc + 16'd2;
            base    = model_regs[ir[8:6]];
            opb     = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_regs[ir[2:0]];
            addr    = base + {{9{ir[5]}}, ir[5:0], 1'b0};
            case (ir[15:12])
                4'b0001: commit_result(ir[11:9], base + opb);
                4'b0101: commit_result(ir[11:9], base & opb);
                4'b1001: commit_result(ir[11:9], ~base);
                4'b1010: begin
                    if (!ir[4]) begin
                        res = base << ir[3:0];
                    end else begin
                        res = base >> ir[3:0];
                        if (ir[5] && base[15])
                            res = res | ~(16'hffff >> ir[3:0]);  // sign fill
                    end
                    commit_result(ir[11:9], res);
                end
                4'b1110: commit_result(ir[11:9], next_pc + {{6{ir[8]}}, ir[8:0], 1'b0});
                4'b0110: commit_result(ir[11:9], model_mem[addr[15:1]]);
                4'b0111: begin
                    model_mem[addr[15:1]] = model_regs[ir[11:9]];
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(model_regs[ir[11:9]]);
                end
                4'b0000: begin
                    if ((ir[11:9] & model_cc) != 3'b000)
                        next_pc = next_pc + {{6{ir[8]}}, ir[8:0], 1'b0};
                end
                4'b1100: next_pc = base;
                default: ;  // reserved codes leave the state alone
            endcase
            pc = next_pc;
            model_count = model_count + 1;
            if (model_count > 5000)
                plain_error("ISA model never reached the halt instruction");
        end
        model_count = model_count + 1;  // the halt itself
    endtask

    // APB slave that samples the bus mid cycle and drives after the next edge
    always begin
        @(negedge clk);
        if (arst_n && psel) begin
            if (!penable) begin
                wait_left   = int'($urandom % 4);
                next_pready = (wait_left == 0);
                next_prdata = mem[paddr[15:1]];
            end else if (pready) begin
                next_pready = 1'b0;
                if (pwrite) begin
                    assert (exp_addr_q.size() != 0)
                        else plain_error("APB write that the ISA model does not make");
                    exp_addr = exp_addr_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    assert (paddr == exp_addr)
                        else value_mismatch("store address", exp_addr, paddr);
                    assert (pwdata == exp_data)
                        else value_mismatch("store data", exp_data, pwdata);
                    mem[paddr[15:1]] = pwdata;
                end else if (paddr == halt_pc) begin
                    halt_hits = halt_hits + 1;
                    if (halt_hits >= `LC3B_HALT_DEPTH)
                        halted = 1'b1;
                end
            end else begin
                wait_left   = wait_left - 1;
                next_pready = (wait_left == 0);
            end
        end
        @(posedge clk);
        #1;
        pready = next_pready;
        prdata = next_prdata;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        assert (cycle_count <= cycle_limit)
            else plain_error($sformatf("timeout, no halt loop after %0d cycles", cycle_count));
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        pready      = 1'b0;
        prdata      = 16'h0;
        halted      = 1'b0;
        halt_hits   = 0;
        cycle_count = 0;
        next_pready = 1'b0;
        next_prdata = 16'h0;
        void'($urandom(32'ha644));
        build_program();
        run_model();
        cycle_limit = 20 * model_count + 200;
        repeat (16) begin
            @(negedge clk);
            assert (!psel && !penable) else plain_error("APB bus active during reset");
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        assert (!psel && !penable) else plain_error("APB bus active in the cycle after reset");
        @(negedge clk);
        assert (psel && !penable) else plain_error("no setup phase right after reset");
        assert (paddr == `LC3B_RESET_PC)
            else value_mismatch("first fetch address", `LC3B_RESET_PC, paddr);
        wait (halted);
        assert (exp_addr_q.size() == 0)
            else plain_error($sformatf("%0d stores never reached the bus", exp_addr_q.size()));
        for (int i = 0; i < 8; i++) begin
            assert (mem[15'((DATA_BASE >> 1) + DUMP_OFF + i)] == model_regs[3'(i)])
                else value_mismatch($sformatf("dump of r%0d", i), model_regs[3'(i)],
                                    mem[15'((DATA_BASE >> 1) + DUMP_OFF + i)]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_lc3b_core

/* lc3b_core.f */
+incdir+source
source/lc3b_isa_pkg.sv
source/lc3b_ctrl_pkg.sv
source/control_rom.sv
source/fetch_unit.sv
source/exec_unit.sv
source/mem_arbiter.sv
source/lc3b_core.sv
tb/tb_lc3b_core.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_lc3b_core
FILELIST = lc3b_core.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exits non-zero on $fatal
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
